// File: hdl/mem_bus_pkg.sv
package mem_bus_pkg;

    // byte address as seen by memory
    typedef logic [31:0] addr_t;

    // one cache block moved per bus transaction
    typedef logic [63:0] block_t;

    // transaction tag returned by memory, zero means no transaction
    typedef logic [3:0] mem_tag_t;

    // bus commands, loads fetch a block and stores write one back
    typedef enum logic [1:0] {
        bus_none,
        bus_load,
        bus_store
    } bus_cmd_t;

    // command bundle driven toward memory
    typedef struct packed {
        bus_cmd_t command;
        addr_t    addr;
        block_t   data;
    } mem_req_t;

    // byte offset bits inside a block
    localparam int block_offset_bits = 3;

endpackage

// File: hdl/dcache_pkg.sv
package dcache_pkg;

    // direct-mapped geometry
    localparam int num_lines  = 32;
    localparam int index_bits = 5;
    localparam int tag_bits   = 24;

    typedef logic [index_bits-1:0] line_index_t;
    typedef logic [tag_bits-1:0]   line_tag_t;

    // access width of a load or store
    typedef enum logic [1:0] {
        size_byte,
        size_half,
        size_word
    } access_size_t;

    typedef enum logic {
        op_load,
        op_store
    } mem_op_t;

    // request from the load/store pipeline
    typedef struct packed {
        logic                valid;
        mem_op_t             op;
        access_size_t        size;
        mem_bus_pkg::addr_t  addr;
        logic [31:0]         write_data;
    } dcache_req_t;

    // registered response, load data zero-extended
    typedef struct packed {
        logic        valid;
        logic [31:0] load_data;
    } dcache_resp_t;

    typedef struct packed {
        logic                valid;
        logic                dirty;
        line_tag_t           tag;
        mem_bus_pkg::block_t block;
    } cache_line_t;

    // dirty victim on its way to the write-back buffer
    typedef struct packed {
        logic                valid;
        mem_bus_pkg::addr_t  addr;
        mem_bus_pkg::block_t block;
    } evict_t;

    // miss handling states of the controller
    typedef enum logic [1:0] {
        st_ready,
        st_fill,
        st_wait_wb
    } ctrl_state_t;

endpackage

// File: hdl/line_store.sv
`timescale 1ns/1ps

module line_store (
    input  logic                    clock,
    input  logic                    reset,
    input  dcache_pkg::dcache_req_t request,
    input  dcache_pkg::dcache_req_t held_req,
    input  logic                    install,
    input  mem_bus_pkg::block_t     fill_block,
    output logic                    hit,
    output mem_bus_pkg::block_t     hit_block,
    output dcache_pkg::evict_t      evict
);
    import mem_bus_pkg::*;
    import dcache_pkg::*;

    cache_line_t lines [num_lines];

    line_index_t req_index;
    line_tag_t   req_tag;
    line_index_t fill_index;
    line_tag_t   fill_tag;
    cache_line_t victim;
    cache_line_t fill_line;
    logic        store_hit;

    // write a byte, half or word into its slot of the block
    function automatic block_t merge_store(block_t blk, addr_t addr, access_size_t size,
                                           logic [31:0] data);
        block_t merged;
        merged = blk;
        case (size)
            size_byte: merged[{addr[2:0], 3'b000} +: 8]   = data[7:0];
            size_half: merged[{addr[2:1], 4'b0000} +: 16] = data[15:0];
            default:   merged[{addr[2], 5'b00000} +: 32]  = data;
        endcase
        return merged;
    endfunction

    // lookup fields of the incoming request
    assign req_index = request.addr[block_offset_bits +: index_bits];
    assign req_tag   = request.addr[block_offset_bits + index_bits +: tag_bits];

    // fill fields come from the held miss
    assign fill_index = held_req.addr[block_offset_bits +: index_bits];
    assign fill_tag   = held_req.addr[block_offset_bits + index_bits +: tag_bits];

    assign hit       = request.valid & lines[req_index].valid & (lines[req_index].tag == req_tag);
    assign hit_block = lines[req_index].block;

    // a valid held request means a miss is outstanding and the pipeline is stalled
    assign store_hit = hit & ~held_req.valid & (request.op == op_store);

    // new line for the fill, store misses merge and go dirty right away
    always_comb begin
        fill_line.valid = 1'b1;
        fill_line.dirty = (held_req.op == op_store);
        fill_line.tag   = fill_tag;
        if (held_req.op == op_store) begin
            fill_line.block = merge_store(fill_block, held_req.addr, held_req.size,
                                          held_req.write_data);
        end else begin
            fill_line.block = fill_block;
        end
    end

    // current occupant of the fill slot
    assign victim = lines[fill_index];

    // only a dirty occupant needs writing back
    always_comb begin
        evict.valid = install & victim.valid & victim.dirty;
        evict.addr  = {victim.tag, fill_index, {block_offset_bits{1'b0}}};
        evict.block = victim.block;
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < num_lines; i++) begin
                lines[i].valid <= 1'b0;
                lines[i].dirty <= 1'b0;
            end
        end else if (install) begin
            lines[fill_index] <= fill_line;
        end else if (store_hit) begin
            lines[req_index].dirty <= 1'b1;
            lines[req_index].block <= merge_store(lines[req_index].block, request.addr,
                                                  request.size, request.write_data);
        end
    end

endmodule

// File: hdl/dcache_ctrl.sv
`timescale 1ns/1ps

module dcache_ctrl (
    input  logic                     clock,
    input  logic                     reset,
    input  dcache_pkg::dcache_req_t  request,
    input  logic                     hit,
    input  mem_bus_pkg::block_t      hit_block,
    input  logic                     wb_pending,
    input  logic                     fill_done,
    input  mem_bus_pkg::block_t      fill_block,
    output dcache_pkg::dcache_req_t  held_req,
    output logic                     start_fill,
    output logic                     install,
    output logic                     stall,
    output dcache_pkg::dcache_resp_t response
);
    import mem_bus_pkg::*;
    import dcache_pkg::*;

    ctrl_state_t  state;
    ctrl_state_t  next_state;
    logic         miss;
    dcache_resp_t next_response;

    // pick the addressed field and zero-extend it
    function automatic logic [31:0] extract_load(block_t blk, addr_t addr, access_size_t size);
        logic [31:0] data;
        data = '0;
        case (size)
            size_byte: data[7:0]  = blk[{addr[2:0], 3'b000} +: 8];
            size_half: data[15:0] = blk[{addr[2:1], 4'b0000} +: 16];
            default:   data       = blk[{addr[2], 5'b00000} +: 32];
        endcase
        return data;
    endfunction

    assign miss    = (state == st_ready) & request.valid & ~hit;
    assign stall   = (state != st_ready);
    // fill lands in the line store in the same cycle it returns
    assign install = (state == st_fill) & fill_done;

    always_comb begin
        next_state = state;
        start_fill = 1'b0;
        case (state)
            st_ready: begin
                // victim slot must be free before the fill goes out
                if (miss & wb_pending) begin
                    next_state = st_wait_wb;
                end else if (miss) begin
                    next_state = st_fill;
                    start_fill = 1'b1;
                end
            end
            st_wait_wb: begin
                if (~wb_pending) begin
                    next_state = st_fill;
                    start_fill = 1'b1;
                end
            end
            st_fill: begin
                if (fill_done) begin
                    next_state = st_ready;
                end
            end
            default: begin
                next_state = st_ready;
            end
        endcase
    end

    // response for a hit or for a finished miss, stores answer with zero
    always_comb begin
        next_response = '0;
        if ((state == st_ready) & request.valid & hit) begin
            next_response.valid = 1'b1;
            if (request.op == op_load) begin
                next_response.load_data = extract_load(hit_block, request.addr, request.size);
            end
        end else if (install) begin
            next_response.valid = 1'b1;
            if (held_req.op == op_load) begin
                next_response.load_data = extract_load(fill_block, held_req.addr, held_req.size);
            end
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            state          <= st_ready;
            held_req.valid <= 1'b0;
            response.valid <= 1'b0;
        end else begin
            state    <= next_state;
            response <= next_response;
            // keep the missing request until its fill is installed
            if (miss) begin
                held_req <= request;
            end else if (install) begin
                held_req.valid <= 1'b0;
            end
        end
    end

endmodule

// File: hdl/refill_unit.sv
`timescale 1ns/1ps

module refill_unit (
    input  logic                  clock,
    input  logic                  reset,
    input  logic                  start_fill,
    input  mem_bus_pkg::addr_t    fill_addr,
    input  mem_bus_pkg::mem_tag_t fill_accept_tag,
    input  mem_bus_pkg::mem_tag_t mem_return_tag,
    input  mem_bus_pkg::block_t   mem_return_data,
    output mem_bus_pkg::mem_req_t fill_req,
    output logic                  fill_done,
    output mem_bus_pkg::block_t   fill_block
);
    import mem_bus_pkg::*;

    // phases of the single miss-status entry
    typedef enum logic [1:0] {
        fill_idle,
        fill_issue,
        fill_wait
    } fill_phase_t;

    fill_phase_t phase;
    mem_tag_t    wait_tag;

    // load is repeated until memory hands back a tag
    always_comb begin
        fill_req.command = (phase == fill_issue) ? bus_load : bus_none;
        fill_req.addr    = {fill_addr[31:block_offset_bits], {block_offset_bits{1'b0}}};
        fill_req.data    = '0;
    end

    // the block arrives with the tag recorded at acceptance
    assign fill_done  = (phase == fill_wait) & (mem_return_tag != '0) &
                        (mem_return_tag == wait_tag);
    assign fill_block = mem_return_data;

    always_ff @(posedge clock) begin
        if (reset) begin
            phase <= fill_idle;
        end else begin
            case (phase)
                fill_idle: begin
                    if (start_fill) begin
                        phase <= fill_issue;
                    end
                end
                fill_issue: begin
                    if (fill_accept_tag != '0) begin
                        phase    <= fill_wait;
                        wait_tag <= fill_accept_tag;
                    end
                end
                fill_wait: begin
                    if (fill_done) begin
                        phase <= fill_idle;
                    end
                end
                default: begin
                    phase <= fill_idle;
                end
            endcase
        end
    end

endmodule

// File: hdl/writeback_buffer.sv
`timescale 1ns/1ps

module writeback_buffer (
    input  logic                  clock,
    input  logic                  reset,
    input  dcache_pkg::evict_t    evict,
    input  logic                  wb_accepted,
    output mem_bus_pkg::mem_req_t wb_req,
    output logic                  wb_pending
);
    import mem_bus_pkg::*;

    logic   full;
    addr_t  wb_addr;
    block_t wb_block;

    assign wb_pending = full;

    // offer the held line as a store while full
    always_comb begin
        wb_req.command = full ? bus_store : bus_none;
        wb_req.addr    = wb_addr;
        wb_req.data    = wb_block;
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            full <= 1'b0;
        end else if (evict.valid) begin
            full     <= 1'b1;
            wb_addr  <= evict.addr;
            wb_block <= evict.block;
        end else if (wb_accepted) begin
            // nothing more to do once memory takes the store
            full <= 1'b0;
        end
    end

endmodule

// File: hdl/mem_arbiter.sv
`timescale 1ns/1ps

module mem_arbiter (
    input  mem_bus_pkg::mem_req_t wb_req,
    input  mem_bus_pkg::mem_req_t fill_req,
    input  mem_bus_pkg::mem_tag_t mem_accept_tag,
    output mem_bus_pkg::mem_req_t mem_req,
    output logic                  wb_accepted,
    output mem_bus_pkg::mem_tag_t fill_accept_tag
);
    import mem_bus_pkg::*;

    logic wb_grant;

    // pending write-back goes before a fill
    assign wb_grant = (wb_req.command == bus_store);

    assign mem_req = wb_grant ? wb_req : fill_req;

    // accept tag only reaches the owner of the granted command
    assign wb_accepted     = wb_grant & (mem_accept_tag != '0);
    assign fill_accept_tag = wb_grant ? '0 : mem_accept_tag;

endmodule

// File: hdl/dcache_top.sv
`timescale 1ns/1ps

module dcache_top (
    input  logic                     clock,
    input  logic                     reset,
    input  dcache_pkg::dcache_req_t  request,
    output logic                     stall,
    output dcache_pkg::dcache_resp_t response,
    output mem_bus_pkg::mem_req_t    mem_req,
    input  mem_bus_pkg::mem_tag_t    mem_accept_tag,
    input  mem_bus_pkg::mem_tag_t    mem_return_tag,
    input  mem_bus_pkg::block_t      mem_return_data
);
    import mem_bus_pkg::*;
    import dcache_pkg::*;

    // controller to line store
    dcache_req_t held_req;
    logic        install;
    logic        hit;
    block_t      hit_block;
    evict_t      evict;

    // refill path
    logic        start_fill;
    logic        fill_done;
    block_t      fill_block;
    mem_req_t    fill_req;
    mem_tag_t    fill_accept_tag;

    // write-back path
    logic        wb_pending;
    logic        wb_accepted;
    mem_req_t    wb_req;

    dcache_ctrl u_ctrl (
        .clock      (clock),
        .reset      (reset),
        .request    (request),
        .hit        (hit),
        .hit_block  (hit_block),
        .wb_pending (wb_pending),
        .fill_done  (fill_done),
        .fill_block (fill_block),
        .held_req   (held_req),
        .start_fill (start_fill),
        .install    (install),
        .stall      (stall),
        .response   (response)
    );

    line_store u_line_store (
        .clock      (clock),
        .reset      (reset),
        .request    (request),
        .held_req   (held_req),
        .install    (install),
        .fill_block (fill_block),
        .hit        (hit),
        .hit_block  (hit_block),
        .evict      (evict)
    );

    // the fill address follows the held miss for the whole fill
    refill_unit u_refill (
        .clock           (clock),
        .reset           (reset),
        .start_fill      (start_fill),
        .fill_addr       (held_req.addr),
        .fill_accept_tag (fill_accept_tag),
        .mem_return_tag  (mem_return_tag),
        .mem_return_data (mem_return_data),
        .fill_req        (fill_req),
        .fill_done       (fill_done),
        .fill_block      (fill_block)
    );

    writeback_buffer u_wb_buffer (
        .clock       (clock),
        .reset       (reset),
        .evict       (evict),
        .wb_accepted (wb_accepted),
        .wb_req      (wb_req),
        .wb_pending  (wb_pending)
    );

    mem_arbiter u_arbiter (
        .wb_req          (wb_req),
        .fill_req        (fill_req),
        .mem_accept_tag  (mem_accept_tag),
        .mem_req         (mem_req),
        .wb_accepted     (wb_accepted),
        .fill_accept_tag (fill_accept_tag)
    );

endmodule

// File: verif/dcache_tb.sv
`timescale 1ns/1ps

module dcache_tb;
    import mem_bus_pkg::*;
    import dcache_pkg::*;

    localparam int wait_limit = 200;

    logic         clock;
    logic         reset;
    dcache_req_t  request;
    logic         stall;
    dcache_resp_t response;
    mem_req_t     mem_req;
    mem_tag_t     mem_accept_tag;
    mem_tag_t     mem_return_tag;
    block_t       mem_return_data;

    // memory contents as seen by the bus, and the expected contents
    block_t mem_array [addr_t];
    block_t golden [addr_t];

    // expected cache state, used to predict hits and write-backs
    logic      model_valid [num_lines];
    logic      model_dirty [num_lines];
    line_tag_t model_tag [num_lines];
    addr_t     wb_addr_q [$];
    block_t    wb_block_q [$];

    // memory model state
    integer seed = 96656;
    logic   offer_seen;
    int     accept_delay;
    int     ret_count;
    addr_t  ret_addr;

    dcache_top UUT (
        .clock           (clock),
        .reset           (reset),
        .request         (request),
        .stall           (stall),
        .response        (response),
        .mem_req         (mem_req),
        .mem_accept_tag  (mem_accept_tag),
        .mem_return_tag  (mem_return_tag),
        .mem_return_data (mem_return_data)
    );

    initial begin
        clock = 1'b0;
        forever #5 clock = ~clock;
    end

    task automatic report_error(input string msg);
        $display("%s", msg);
        $display("*** FAILED ***");
        $fatal(1);
    endtask

    task automatic check_resp(input dcache_resp_t got, input logic [31:0] exp);
        if (got.valid !== 1'b1) begin
            report_error($sformatf("FAIL response.valid got 0x%0h expected 0x1", got.valid));
        end
        if (got.load_data !== exp) begin
            report_error($sformatf("FAIL response.load_data got 0x%08h expected 0x%08h",
                                   got.load_data, exp));
        end
    endtask

    task automatic check_valid(input logic got, input logic exp);
        if (got !== exp) begin
            report_error($sformatf("FAIL response.valid got 0x%0h expected 0x%0h", got, exp));
        end
    endtask

    task automatic check_stall(input logic got, input logic exp);
        if (got !== exp) begin
            report_error($sformatf("FAIL stall got 0x%0h expected 0x%0h", got, exp));
        end
    endtask

    task automatic check_cmd(input bus_cmd_t got, input bus_cmd_t exp);
        if (got !== exp) begin
            report_error($sformatf("FAIL mem_req.command got 0x%0h expected 0x%0h", got, exp));
        end
    endtask

    task automatic check_mem_store(input mem_req_t got, input addr_t exp_addr,
                                   input block_t exp_block);
        check_cmd(got.command, bus_store);
        if (got.addr !== exp_addr) begin
            report_error($sformatf("FAIL mem_req.addr got 0x%08h expected 0x%08h",
                                   got.addr, exp_addr));
        end
        if (got.data !== exp_block) begin
            report_error($sformatf("FAIL mem_req.data got 0x%016h expected 0x%016h",
                                   got.data, exp_block));
        end
    endtask

    // every word of an untouched block holds its own byte address
    function automatic block_t pattern_block(input addr_t base);
        return {base + 32'd4, base};
    endfunction

    function automatic block_t mem_block(input addr_t base);
        if (mem_array.exists(base)) begin
            return mem_array[base];
        end
        return pattern_block(base);
    endfunction

    function automatic block_t golden_block(input addr_t base);
        if (golden.exists(base)) begin
            return golden[base];
        end
        return pattern_block(base);
    endfunction

    // byte lanes of a store, little endian inside the block
    task automatic apply_golden_store(input addr_t addr, input access_size_t size,
                                      input logic [31:0] data);
        addr_t  base;
        block_t blk;
        int     nbytes;
        base   = {addr[31:3], 3'b000};
        blk    = golden_block(base);
        nbytes = (size == size_byte) ? 1 : ((size == size_half) ? 2 : 4);
        for (int b = 0; b < nbytes; b++) begin
            blk[(addr[2:0] + b) * 8 +: 8] = data[b * 8 +: 8];
        end
        golden[base] = blk;
    endtask

    // direct-mapped prediction, a dirty victim queues its expected write-back
    task automatic predict_access(input logic is_store, input addr_t addr,
                                  output logic is_hit);
        line_index_t idx;
        line_tag_t   tg;
        addr_t       victim;
        idx    = addr[block_offset_bits +: index_bits];
        tg     = addr[block_offset_bits + index_bits +: tag_bits];
        is_hit = model_valid[idx] && (model_tag[idx] == tg);
        if (!is_hit) begin
            if (model_valid[idx] && model_dirty[idx]) begin
                victim = {model_tag[idx], idx, 3'b000};
                wb_addr_q.push_back(victim);
                wb_block_q.push_back(golden_block(victim));
            end
            model_valid[idx] = 1'b1;
            model_dirty[idx] = 1'b0;
            model_tag[idx]   = tg;
        end
        if (is_store) begin
            model_dirty[idx] = 1'b1;
        end
    endtask

    task automatic accept_command(input mem_req_t req);
        addr_t  exp_addr;
        block_t exp_block;
        if (req.command == bus_store) begin
            if (wb_addr_q.size() == 0) begin
                report_error($sformatf("unexpected write-back to address 0x%08h", req.addr));
            end
            exp_addr  = wb_addr_q.pop_front();
            exp_block = wb_block_q.pop_front();
            check_mem_store(req, exp_addr, exp_block);
            mem_array[req.addr] = req.data;
        end else begin
            ret_addr  = req.addr;
            ret_count = 4;
        end
    endtask

    // memory model, accepts after a random delay and answers loads 4 cycles later
    always @(posedge clock) begin
        #1;
        mem_accept_tag = '0;
        mem_return_tag = '0;
        if (reset) begin
            offer_seen = 1'b0;
            ret_count  = 0;
        end else begin
            if (ret_count > 0) begin
                ret_count--;
                if (ret_count == 0) begin
                    mem_return_tag  = 4'd1;
                    mem_return_data = mem_block(ret_addr);
                end
            end
            if (mem_req.command != bus_none) begin
                // new offer draws its own delay
                if (!offer_seen) begin
                    offer_seen   = 1'b1;
                    accept_delay = $unsigned($random(seed)) % 4;
                end
                if (accept_delay == 0) begin
                    mem_accept_tag = 4'd1;
                    offer_seen     = 1'b0;
                    accept_command(mem_req);
                end else begin
                    accept_delay--;
                end
            end
        end
    end

    // one access from issue to response, stall checked every cycle
    task automatic run_access(input mem_op_t op, input access_size_t size, input addr_t addr,
                              input logic [31:0] wdata, input logic [31:0] exp);
        int   cycles;
        logic is_hit;
        cycles = 0;
        while (stall) begin
            @(posedge clock);
            #1;
            cycles++;
            if (cycles > wait_limit) begin
                report_error("timed out waiting for stall to drop before a request");
            end
        end
        check_valid(response.valid, 1'b0);
        predict_access(op == op_store, addr, is_hit);
        if (op == op_store) begin
            apply_golden_store(addr, size, wdata);
        end
        request.valid      = 1'b1;
        request.op         = op;
        request.size       = size;
        request.addr       = addr;
        request.write_data = wdata;
        @(posedge clock);
        #1;
        request = '0;
        cycles  = 0;
        while (!response.valid) begin
            check_stall(stall, 1'b1);
            @(posedge clock);
            #1;
            cycles++;
            if (cycles > wait_limit) begin
                report_error($sformatf("timed out waiting for a response at 0x%08h", addr));
            end
        end
        // stall drops together with the response
        check_stall(stall, 1'b0);
        if (is_hit && cycles != 0) begin
            report_error($sformatf("hit at 0x%08h was not answered in the next cycle", addr));
        end
        if (!is_hit && cycles == 0) begin
            report_error($sformatf("miss at 0x%08h was answered without a stall", addr));
        end
        check_resp(response, (op == op_store) ? 32'h0 : exp);
        @(posedge clock);
        #1;
        check_valid(response.valid, 1'b0);
    endtask

    initial begin
        int          fd;
        int          n;
        int          cycles;
        string       line;
        logic [31:0] op_val;
        logic [31:0] size_val;
        logic [31:0] addr_val;
        logic [31:0] wdata_val;
        logic [31:0] exp_val;
        reset           = 1'b1;
        request         = '0;
        mem_accept_tag  = '0;
        mem_return_tag  = '0;
        mem_return_data = '0;
        for (int i = 0; i < num_lines; i++) begin
            model_valid[i] = 1'b0;
            model_dirty[i] = 1'b0;
            model_tag[i]   = '0;
        end
        repeat (5) @(posedge clock);
        #1;
        reset = 1'b0;
        // idle state right after reset
        check_stall(stall, 1'b0);
        check_valid(response.valid, 1'b0);
        check_cmd(mem_req.command, bus_none);

        fd = $fopen("verif/dcache_input.txt", "r");
        if (fd == 0) begin
            report_error("could not open verif/dcache_input.txt");
        end
        while (!$feof(fd)) begin
            n = $fgets(line, fd);
            // skip comment and blank lines
            if (n > 1 && line.getc(0) != "#") begin
                n = $sscanf(line, "%h %h %h %h %h", op_val, size_val, addr_val,
                            wdata_val, exp_val);
                if (n != 5) begin
                    report_error($sformatf("malformed line in data file: %s", line));
                end
                run_access(mem_op_t'(op_val[0]), access_size_t'(size_val[1:0]), addr_val,
                           wdata_val, exp_val);
            end
        end
        $fclose(fd);

        // last write-back may still be on its way
        cycles = 0;
        while (wb_addr_q.size() != 0) begin
            @(posedge clock);
            #1;
            cycles++;
            if (cycles > wait_limit) begin
                report_error("an expected write-back never reached memory");
            end
        end
        $display("*** PASSED ***");
        $finish;
    end

endmodule

// File: verif/dcache_input.txt
# op (0 load, 1 store)  size (0 byte, 1 half, 2 word)  address  write data  expected load data
# all values in hex, stores expect zero load data
0 2 00001000 00000000 00001000
0 2 00001004 00000000 00001004
1 0 00001001 000000ab 00000000
0 2 00001000 00000000 0000ab00
1 1 00001006 0000beef 00000000
0 2 00001004 00000000 beef1004
0 1 00001006 00000000 0000beef
0 0 00001007 00000000 000000be
1 2 00001000 12345678 00000000
0 0 00001003 00000000 00000012
0 1 00001002 00000000 00001234
0 2 00001100 00000000 00001100
0 2 00001104 00000000 00001104
0 2 00001000 00000000 12345678
0 2 00001004 00000000 beef1004
1 2 00002008 cafef00d 00000000
0 2 0000200c 00000000 0000200c
0 2 00002008 00000000 cafef00d
0 2 00003008 00000000 00003008
0 0 0000200b 00000000 000000ca
0 2 00000010 00000000 00000010
0 2 00000110 00000000 00000110

// File: verilog.f
hdl/mem_bus_pkg.sv
hdl/dcache_pkg.sv
hdl/line_store.sv
hdl/dcache_ctrl.sv
hdl/refill_unit.sv
hdl/writeback_buffer.sv
hdl/mem_arbiter.sv
hdl/dcache_top.sv
verif/dcache_tb.sv

// File: Bender.yml
package:
  name: dcache

sources:
  - hdl/mem_bus_pkg.sv
  - hdl/dcache_pkg.sv
  - hdl/line_store.sv
  - hdl/dcache_ctrl.sv
  - hdl/refill_unit.sv
  - hdl/writeback_buffer.sv
  - hdl/mem_arbiter.sv
  - hdl/dcache_top.sv
  - target: simulation
    files:
      - verif/dcache_tb.sv
